// ==== list.f ====
+incdir+.
cpu_pkg.sv
cpu_control.sv
cpu_alu.sv
cpu_regs.sv
cpu_pointers.sv
cpu_memory.sv
cpu_top.sv
cpu_tb.sv

// ==== cpu_tb_model.svh ====
`ifndef CPU_TB_MODEL_SVH
`define CPU_TB_MODEL_SVH

// instruction-set model state, advanced once per retired instruction
data_t  m_a, m_b, m_pl, m_ph;
flags_t m_flags;                        // {v, n, c, z}
addr_t  m_ip;
data_t  m_mem [`CPU_RAM_DEPTH];
data_t  img [`CPU_RAM_DEPTH];           // image for the program port

task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
        $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        report_fail();
    end
endtask

task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
        $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        report_fail();
    end
endtask

task automatic check_trace(input string name, input trace_t got, input trace_t exp);
    check_addr({name, ".addr"}, got.addr, exp.addr);
    check_data({name, ".data"}, got.data, exp.data);
endtask

function automatic data_t reg_value(input logic [1:0] r);
    case (r)
        2'd1:    return m_b;
        2'd2:    return m_pl;
        2'd3:    return m_ph;
        default: return '0;             // operand code 0 is zero
    endcase
endfunction

task automatic write_reg(input logic [1:0] r, input data_t v);
    case (r)
        2'd0: m_a = v;                  // destination code 0 is a
        2'd1: m_b = v;
        2'd2: m_pl = v;
        2'd3: m_ph = v;
    endcase
endtask

task automatic alu_model(input logic [3:0] op, input data_t x, input data_t y,
                         input logic cin, output data_t res, output flags_t f);
    int   s;
    int   sv;
    logic c;
    logic v;
    s = 0;
    sv = 0;
    c = 1'b0;
    v = 1'b0;
    res = '0;
    case (alu_op_e'(op))
        ALU_ADD, ALU_ADC: begin
            s   = int'(x) + int'(y) + ((op == ALU_ADC) ? int'(cin) : 0);
            sv  = int'($signed(x)) + int'($signed(y)) + ((op == ALU_ADC) ? int'(cin) : 0);
            c   = s > 255;
            v   = (sv > 127) || (sv < -128);
            res = s[7:0];
        end
        ALU_SUB, ALU_SBC, ALU_CMP: begin
            s   = int'(x) - int'(y) - ((op == ALU_SBC) ? int'(cin) : 0);
            sv  = int'($signed(x)) - int'($signed(y)) - ((op == ALU_SBC) ? int'(cin) : 0);
            c   = s < 0;                // borrow
            v   = (sv > 127) || (sv < -128);
            res = s[7:0];
        end
        ALU_INC: begin res = x + 1'b1; c = x == 8'hff; v = x == 8'h7f; end
        ALU_DEC: begin res = x - 1'b1; c = x == 8'h00; v = x == 8'h80; end
        ALU_AND:  res = x & y;
        ALU_OR:   res = x | y;
        ALU_XOR:  res = x ^ y;
        ALU_PASS: res = y;
        ALU_NOT:  res = ~x;
        ALU_SHL: begin res = {x[6:0], 1'b0}; c = x[7]; end
        ALU_SHR: begin res = {1'b0, x[7:1]}; c = x[0]; end
        ALU_ROL: begin res = {x[6:0], x[7]}; c = x[7]; end
        ALU_ROR: begin res = {x[0], x[7:1]}; c = x[0]; end
        default: ;
    endcase
    f = {v, res[7], c, res == '0};
endtask

// one instruction at m_ip, every opcode byte decodes to something
task automatic model_step(output addr_t ip_here, output logic is_st, output trace_t st);
    instr_t ins;
    data_t  x, y, sel, res;
    flags_t f;
    addr_t  tmp;
    ins = m_mem[m_ip[7:0]];
    ip_here = m_ip;
    is_st = 1'b0;
    st = '0;
    if (!ins[7]) begin
        sel = reg_value(ins[1:0]);
        x = ins[2] ? sel : m_a;
        y = ins[2] ? m_a : sel;
        alu_model(ins[6:3], x, y, m_flags[1], res, f);
        m_flags = f;
        if (ins[6:3] != 4'hf)           // cmp writes flags only
            write_reg(ins[2] ? ins[1:0] : 2'd0, res);
        m_ip = m_ip + 1'b1;
    end else if (ins[7:4] == 4'b1000) begin
        write_reg(ins[1:0], m_mem[m_pl]);   // ph:pl wraps to pl
        m_ip = m_ip + 1'b1;
    end else if (ins[7:4] == 4'b1010) begin
        tmp = m_ip + 1'b1;
        write_reg(ins[1:0], m_mem[tmp[7:0]]);
        m_ip = m_ip + 2'd2;
    end else if (ins[7:4] == 4'b1011) begin
        is_st = 1'b1;
        st.addr = {m_ph, m_pl};
        st.data = ins[0] ? m_b : m_a;
        m_mem[m_pl] = st.data;
        m_ip = m_ip + 1'b1;
    end else if (ins[7:6] == 2'b11 && (ins[3] || (ins[2] ^ m_flags[ins[1:0]]))) begin
        tmp = m_ip;
        m_ip = {m_ph, m_pl};
        {m_ph, m_pl} = tmp;
    end else begin
        m_ip = m_ip + 1'b1;             // untaken jump or 1001 filler
    end
endtask

`endif

// ==== cpu_tb.sv ====
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpu_tb import cpu_pkg::*; ();

    localparam int N_INSTR    = 64;
    localparam int CLK_NS     = 4;
    localparam int TIMEOUT_NS = (16 + 4 + `CPU_RAM_DEPTH + N_INSTR * 4 + 100) * CLK_NS;

    logic   clk, rst, run, prog_we;
    addr_t  prog_addr;
    data_t  prog_data;
    logic   retire, store_valid;
    addr_t  retire_ip;
    trace_t store_trace;
    trace_t exp_stores[$];
    int     retired;

    task automatic report_fail();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    `include "cpu_tb_model.svh"

    cpu_top UUT (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .retire      (retire),
        .retire_ip   (retire_ip),
        .store_valid (store_valid),
        .store_trace (store_trace)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // two LDIs aim DP at the data area before the random part
    task automatic gen_program();
        int     pc, n, k, alu_n;
        logic [1:0] r;
        logic   d;
        alu_n = 0;
        img[0] = 8'ha3;                             // ldi ph
        img[1] = 8'h00;
        img[2] = 8'ha2;
        img[3] = 8'hc0 | 8'($urandom_range(0, 63));
        pc = 4;
        n = 2;
        while (n < N_INSTR) begin
            k = $urandom_range(0, 99);
            r = 2'($urandom_range(0, 2));   // ph stays untouched
            if (k < 50 && n < N_INSTR - 1) begin
                d = 1'($urandom);
                img[pc] = {1'b0, 4'(alu_n), d, r};
                // ST takes b only when b got the result
                img[pc + 1] = (d && r == 2'd1) ? 8'hb1 : 8'hb0;
                alu_n++;    // cycles all 16 ops
                pc += 2;
                n += 2;
            end else if (k < 60) begin
                img[pc] = 8'hb0 | 8'($urandom_range(0, 1));
                pc++;
                n++;
            end else if (k < 70) begin
                img[pc] = {6'b100000, r};
                pc++;
                n++;
            end else if (k < 82) begin
                img[pc] = {6'b101000, r};
                img[pc + 1] = (r == 2'd2) ? (8'hc0 | 8'($urandom_range(0, 63)))
                                          : 8'($urandom);
                pc += 2;
                n++;
            end else begin
                img[pc] = 8'hc0 | 8'($urandom_range(0, 15));  // Jc or JMP
                pc++;
                n++;
            end
        end
        for (int i = pc; i < `CPU_RAM_DEPTH; i++)
            img[i] = 8'($urandom);
    endtask

    initial begin
        rst = 1'b0;
        run = 1'b0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        retired = 0;
        void'($urandom(85));
        m_a = '0;
        m_b = '0;
        m_pl = '0;
        m_ph = '0;
        m_flags = '0;
        m_ip = '0;
        gen_program();
        for (int i = 0; i < `CPU_RAM_DEPTH; i++)
            m_mem[i] = img[i];
        repeat (16) @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < `CPU_RAM_DEPTH; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= addr_t'(i);
            prog_data <= img[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        run     <= 1'b1;
        wait (retired >= N_INSTR);
        repeat (2) @(posedge clk);
        $display("TEST OK");
        $finish;
    end

    // outputs are sampled mid-cycle
    always @(negedge clk) begin : monitor
        addr_t  exp_ip;
        logic   is_st;
        trace_t st;
        if (!rst || !run) begin
            if (retire !== 1'b0 || store_valid !== 1'b0) begin
                $display("retire or store_valid active while reset or stopped");
                report_fail();
            end
        end else begin
            if (retire === 1'b1) begin
                model_step(exp_ip, is_st, st);
                check_addr("retire_ip", retire_ip, exp_ip);
                if (is_st)
                    exp_stores.push_back(st);
                retired++;
            end
            if (store_valid === 1'b1) begin
                if (exp_stores.size() == 0) begin
                    $display("store seen at %0t ns with no expected store", $time);
                    report_fail();
                end
                check_trace("store_trace", store_trace, exp_stores.pop_front());
            end else if (exp_stores.size() != 0) begin
                $display("expected store missing at %0t ns", $time);
                report_fail();
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout: the processor stopped retiring instructions");
        report_fail();
    end

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/100ps

module cpu_top import cpu_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   run,
    input  logic   prog_we,
    input  addr_t  prog_addr,
    input  data_t  prog_data,
    output logic   retire,
    output addr_t  retire_ip,
    output logic   store_valid,
    output trace_t store_trace
);

    dp_ctrl_t  dp_ctrl;
    ptr_ctrl_t ptr_ctrl;
    alu_op_e   alu_op;
    logic      dir;
    logic      mem_we;
    logic      retire_d;
    flags_t    flags, alu_flags;
    data_t     alu_x, alu_y, alu_result;
    data_t     store_data, rdata;
    addr_t     dp, ip, addr;

    cpu_control u_control (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .rdata       (rdata),
        .flags       (flags),
        .dp_ctrl     (dp_ctrl),
        .ptr_ctrl    (ptr_ctrl),
        .alu_op      (alu_op),
        .dir         (dir),
        .mem_we      (mem_we),
        .retire      (retire),
        .store_valid (store_valid)
    );

    cpu_alu u_alu (
        .op        (alu_op),
        .x         (alu_x),
        .y         (alu_y),
        .carry_in  (flags[FLAG_C]),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

    cpu_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (dp_ctrl),
        .dir        (dir),
        .mem_data   (rdata),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .ip         (ip),
        .alu_x      (alu_x),
        .alu_y      (alu_y),
        .store_data (store_data),
        .flags      (flags),
        .dp         (dp)
    );

    cpu_pointers u_pointers (
        .clk  (clk),
        .rst  (rst),
        .ctrl (ptr_ctrl),
        .dp   (dp),
        .addr (addr),
        .ip   (ip)
    );

    cpu_memory u_memory (
        .clk       (clk),
        .run       (run),
        .addr      (addr),
        .we        (mem_we),
        .wdata     (store_data),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .rdata     (rdata)
    );

    // the cycle after a retire is the next fetch, IP is that instruction's address
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            retire_d  <= 1'b0;
            retire_ip <= '0;
        end else begin
            retire_d <= retire;
            if (retire_d)
                retire_ip <= ip;   // held until LDI moves IP
        end
    end

    assign store_trace.addr = addr;        // DP during ST exec
    assign store_trace.data = store_data;

endmodule

// ==== cpu_memory.sv ====
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpu_memory import cpu_pkg::*; (
    input  logic  clk,
    input  logic  run,
    input  addr_t addr,
    input  logic  we,
    input  data_t wdata,
    input  logic  prog_we,
    input  addr_t prog_addr,
    input  data_t prog_data,
    output data_t rdata
);

    localparam int IDX_W = $clog2(`CPU_RAM_DEPTH);

    data_t            ram [`CPU_RAM_DEPTH];
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] prog_idx;
    logic             load_wr;

    // upper address bits are ignored, so addresses wrap
    assign idx      = addr[IDX_W-1:0];
    assign prog_idx = prog_addr[IDX_W-1:0];
    assign load_wr  = prog_we & ~run;   // loader only while stopped

    always_ff @(posedge clk) begin
        if (load_wr)
            ram[prog_idx] <= prog_data;
        else if (we)
            ram[idx] <= wdata;
        rdata <= ram[idx];  // old contents on a same-address write
    end

endmodule

// ==== cpu_pointers.sv ====
`timescale 1ns/100ps

module cpu_pointers import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  ptr_ctrl_t ctrl,
    input  addr_t     dp,
    output addr_t     addr,
    output addr_t     ip
);

    addr_t ip_nx;

    // swap and increment never come together
    always_comb begin
        ip_nx = ip;
        if (ctrl.swap_p)
            ip_nx = dp;
        else if (ctrl.ip_inc)
            ip_nx = ip + 1'b1;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            ip <= '0;       // execution starts at address 0
        else
            ip <= ip_nx;
    end

    assign addr = ctrl.addr_dp ? dp : ip;   // LD and ST go through DP

endmodule

// ==== cpu_regs.sv ====
`timescale 1ns/100ps

module cpu_regs import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  dp_ctrl_t ctrl,
    input  logic     dir,
    input  data_t    mem_data,
    input  data_t    alu_result,
    input  flags_t   alu_flags,
    input  addr_t    ip,          // old IP for the swap
    output data_t    alu_x,
    output data_t    alu_y,
    output data_t    store_data,
    output flags_t   flags,
    output addr_t    dp
);

    data_t a, b, pl, ph;
    data_t sel_val;
    data_t wr_data;
    logic  pair_wr;

    always_comb begin
        case (ctrl.src_sel)
            REG_B:   sel_val = b;
            REG_PL:  sel_val = pl;
            REG_PH:  sel_val = ph;
            default: sel_val = '0;   // operand code 0 is the constant zero
        endcase
    end

    // dir 1 turns the selected register into the destination side
    assign alu_x      = dir ? sel_val : a;
    assign alu_y      = dir ? a : sel_val;
    assign store_data = (ctrl.src_sel == REG_B) ? b : a;
    assign wr_data    = ctrl.wr_from_mem ? mem_data : alu_result;
    assign pair_wr    = ctrl.we_pl & ctrl.we_ph & ~ctrl.wr_from_mem;
    assign dp         = {ph, pl};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            a     <= '0;
            b     <= '0;
            pl    <= '0;
            ph    <= '0;
            flags <= '0;
        end else begin
            if (ctrl.we_a) a <= wr_data;
            if (ctrl.we_b) b <= wr_data;
            if (pair_wr) begin
                {ph, pl} <= ip;      // jump swap
            end else begin
                if (ctrl.we_pl) pl <= wr_data;
                if (ctrl.we_ph) ph <= wr_data;
            end
            if (ctrl.we_flags) flags <= alu_flags;
        end
    end

endmodule

// ==== cpu_alu.sv ====
`timescale 1ns/100ps

module cpu_alu import cpu_pkg::*; (
    input  alu_op_e op,
    input  data_t   x,
    input  data_t   y,
    input  logic    carry_in,
    output data_t   result,
    output flags_t  flags_out
);

    localparam int W = $bits(data_t);

    logic [W:0] sum;        // extra bit holds carry or borrow
    data_t      val;        // value the z and n flags look at
    logic       c, v;

    always_comb begin
        sum    = '0;
        val    = '0;
        c      = 1'b0;
        v      = 1'b0;
        result = '0;
        case (op)
            ALU_ADD, ALU_ADC: begin
                sum = {1'b0, x} + {1'b0, y} + {{W{1'b0}}, carry_in & (op == ALU_ADC)};
                c   = sum[W];
                v   = (x[W-1] == y[W-1]) && (sum[W-1] != x[W-1]);
                val = sum[W-1:0];
            end
            ALU_SUB, ALU_SBC, ALU_CMP: begin
                sum = {1'b0, x} - {1'b0, y} - {{W{1'b0}}, carry_in & (op == ALU_SBC)};
                c   = sum[W];             // borrow
                v   = (x[W-1] != y[W-1]) && (sum[W-1] != x[W-1]);
                val = sum[W-1:0];
            end
            ALU_INC: begin
                sum = {1'b0, x} + 1'b1;
                c   = sum[W];
                v   = ~x[W-1] & sum[W-1];
                val = sum[W-1:0];
            end
            ALU_DEC: begin
                sum = {1'b0, x} - 1'b1;
                c   = sum[W];
                v   = x[W-1] & ~sum[W-1];
                val = sum[W-1:0];
            end
            ALU_AND:  val = x & y;
            ALU_OR:   val = x | y;
            ALU_XOR:  val = x ^ y;
            ALU_PASS: val = y;                 // plain move
            ALU_NOT:  val = ~x;
            ALU_SHL:  begin val = {x[W-2:0], 1'b0};    c = x[W-1]; end
            ALU_SHR:  begin val = {1'b0, x[W-1:1]};    c = x[0];   end
            ALU_ROL:  begin val = {x[W-2:0], x[W-1]};  c = x[W-1]; end
            ALU_ROR:  begin val = {x[0], x[W-1:1]};    c = x[0];   end
            default: ;
        endcase
        result = (op == ALU_CMP) ? x : val;   // cmp leaves the operand as is

        flags_out         = '0;
        flags_out[FLAG_Z] = val == '0;
        flags_out[FLAG_C] = c;
        flags_out[FLAG_N] = val[W-1];
        flags_out[FLAG_V] = v;
    end

endmodule

// ==== cpu_control.sv ====
`timescale 1ns/100ps

// ALU: 0oooodrr   LD: 1000__rr   LDI: 1010__rr   ST: 1011___s
// Jc:  11000iff   JMP: 11001___
module cpu_control import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      run,
    input  data_t     rdata,
    input  flags_t    flags,
    output dp_ctrl_t  dp_ctrl,
    output ptr_ctrl_t ptr_ctrl,
    output alu_op_e   alu_op,
    output logic      dir,
    output logic      mem_we,
    output logic      retire,
    output logic      store_valid
);

    ctrl_state_e state, state_nx;
    instr_t      ir;
    logic        is_alu, is_ld, is_ldi, is_st, is_jmp, is_cmp;
    logic        two_step;      // LD and LDI need the wb cycle
    logic        take;
    reg_sel_e    dst;
    reg_sel_e    wr_sel;
    logic        wr_en;

    assign is_alu   = ~ir[7];
    assign is_ld    = ir[7:4] == 4'b1000;
    assign is_ldi   = ir[7:4] == 4'b1010;
    assign is_st    = ir[7:4] == 4'b1011;
    assign is_jmp   = ir[7:6] == 2'b11;   // Jc and JMP
    assign is_cmp   = is_alu && (alu_op == ALU_CMP);
    assign two_step = is_ld | is_ldi;
    assign dst      = reg_sel_e'(ir[1:0]);

    // bit 3 forces the jump, bit 2 inverts the selected flag
    assign take = ir[3] | (ir[2] ^ flags[ir[1:0]]);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= ST_FETCH;
            ir    <= '0;
        end else begin
            state <= state_nx;
            if (state == ST_DECODE)
                ir <= rdata;      // fetch data arrives here
        end
    end

    always_comb begin
        case (state)
            ST_FETCH:  state_nx = run ? ST_DECODE : ST_FETCH;
            ST_DECODE: state_nx = ST_EXEC;
            ST_EXEC:   state_nx = two_step ? ST_WB : ST_FETCH;
            default:   state_nx = ST_FETCH;
        endcase
    end

    assign alu_op      = alu_op_e'(ir[6:3]);
    assign dir         = ir[2];
    assign retire      = ((state == ST_EXEC) && !two_step) || (state == ST_WB);
    assign store_valid = (state == ST_EXEC) && is_st;
    assign mem_we      = store_valid;

    always_comb begin
        dp_ctrl         = '0;
        dp_ctrl.src_sel = dst;
        ptr_ctrl        = '0;
        wr_en           = 1'b0;
        wr_sel          = dst;

        case (state)
            ST_DECODE: begin
                // LDI steps IP onto its immediate before exec reads it
                ptr_ctrl.ip_inc = rdata[7:4] == 4'b1010;
            end
            ST_EXEC: begin
                ptr_ctrl.addr_dp = is_ld | is_st;
                if (is_jmp && take) begin
                    ptr_ctrl.swap_p = 1'b1;
                    dp_ctrl.we_pl   = 1'b1;   // both set means pair load
                    dp_ctrl.we_ph   = 1'b1;
                end else if (!two_step) begin
                    ptr_ctrl.ip_inc = 1'b1;
                end
                if (is_st)
                    dp_ctrl.src_sel = ir[0] ? REG_B : REG_ZA;
                if (is_alu) begin
                    dp_ctrl.we_flags = 1'b1;
                    wr_en  = !is_cmp;         // cmp only updates flags
                    wr_sel = dir ? dst : REG_ZA;
                end
            end
            ST_WB: begin
                ptr_ctrl.ip_inc     = 1'b1;
                dp_ctrl.wr_from_mem = 1'b1;
                wr_en               = 1'b1;
            end
            default: ;
        endcase

        dp_ctrl.we_a  = wr_en && (wr_sel == REG_ZA);
        dp_ctrl.we_b  = wr_en && (wr_sel == REG_B);
        dp_ctrl.we_pl = dp_ctrl.we_pl | (wr_en && (wr_sel == REG_PL));
        dp_ctrl.we_ph = dp_ctrl.we_ph | (wr_en && (wr_sel == REG_PH));
    end

endmodule

// ==== cpu_pkg.sv ====
`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_ADDR_W-1:0] addr_t;
    typedef logic [`CPU_DATA_W-1:0] data_t;
    typedef logic [7:0] instr_t;
    typedef logic [3:0] flags_t;    // {v, n, c, z}

    // bit positions inside flags_t, also the Jc flag select
    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;
    localparam int FLAG_N = 2;
    localparam int FLAG_V = 3;

    typedef enum logic [3:0] {
        ALU_ADD,  ALU_ADC, ALU_SUB, ALU_SBC,
        ALU_AND,  ALU_OR,  ALU_XOR, ALU_PASS,
        ALU_INC,  ALU_DEC, ALU_SHL, ALU_SHR,
        ALU_ROL,  ALU_ROR, ALU_NOT, ALU_CMP
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_FETCH, ST_DECODE, ST_EXEC, ST_WB
    } ctrl_state_e;

    // code 0 reads as zero on the ALU side, writes a as destination
    typedef enum logic [1:0] {
        REG_ZA, REG_B, REG_PL, REG_PH
    } reg_sel_e;

    typedef struct packed {
        logic     we_a;
        logic     we_b;
        logic     we_pl;        // pl and ph together load old IP on a swap
        logic     we_ph;
        reg_sel_e src_sel;
        logic     wr_from_mem;  // memory byte instead of ALU result
        logic     we_flags;
    } dp_ctrl_t;

    typedef struct packed {
        logic ip_inc;
        logic swap_p;
        logic addr_dp;          // address from DP instead of IP
    } ptr_ctrl_t;

    typedef struct packed {
        addr_t addr;
        data_t data;
    } trace_t;

endpackage

// ==== cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// core widths
`define CPU_ADDR_W 16           // IP and DP width
`define CPU_DATA_W 8            // register and memory byte

// internal RAM size in bytes
// addresses wrap modulo this depth
`define CPU_RAM_DEPTH 256

`endif
